//--- Makefile
SIM  := obj_dir/Vstream_link_tb
SRCS := $(shell grep -v '^+' stream_link.f)

.PHONY: run clean

run: $(SIM)
	$(SIM) > sim.log 2>&1; cat sim.log
	grep -q '^TESTS PASSED$$' sim.log

$(SIM): stream_link.f $(SRCS)
	verilator --binary --timing --assert --top-module stream_link_tb \
		-f stream_link.f -Mdir obj_dir -o Vstream_link_tb

clean:
	rm -rf obj_dir sim.log

//--- stream_link.f
verilog/lane_pkg.sv
verilog/link_trainer.sv
verilog/word_fifo.sv
verilog/frame_packer.sv
verilog/stream_link_top.sv
testbench/clock_gen.sv
testbench/stream_link_sva.sv
testbench/stream_link_tb.sv

//--- testbench/clock_gen.sv
`default_nettype none

module clock_gen (
    output logic txclk_div,
    output logic reset_n
);

    // 40 unit period
    initial begin
        txclk_div = 1'b0;
        forever begin
            #20 txclk_div = ~txclk_div;
        end
    end

    // reset held over the first two rising edges
    initial begin
        reset_n = 1'b1;
        repeat (2) @(posedge txclk_div);
        #1 reset_n = 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/stream_link_sva.sv
`default_nettype none

module stream_link_sva #(
    parameter int FIFO_DEPTH = 8
) (
    input wire logic                        txclk_div,
    input wire logic                        reset_n,
    input wire lane_pkg::link_cmd_t         link_cmd,
    input wire logic                        frame_valid,
    input wire logic                        in_ready,
    input wire logic [$clog2(FIFO_DEPTH):0] fifo_count
);

    // frames only in the data stage
    frame_in_data: assert property (
        @(posedge txclk_div) disable iff (reset_n)
        $rose(frame_valid) |-> link_cmd == lane_pkg::CMD_DATA
    ) else $error("frame_valid rose outside the data stage");

    // settle lasts a single cycle before data
    settle_one_cycle: assert property (
        @(posedge txclk_div) disable iff (reset_n)
        link_cmd == lane_pkg::CMD_SETTLE |=> link_cmd == lane_pkg::CMD_DATA
    ) else $error("settle stage did not last exactly one cycle");

    // a full buffer takes nothing in
    no_push_when_full: assert property (
        @(posedge txclk_div) disable iff (reset_n)
        !in_ready |=> fifo_count <= $past(fifo_count)
    ) else $error("word accepted while in_ready was low");

endmodule

bind stream_link_top stream_link_sva #(
    .FIFO_DEPTH (FIFO_DEPTH)
) i_sva (
    .txclk_div   (txclk_div),
    .reset_n     (reset_n),
    .link_cmd    (link_cmd),
    .frame_valid (frame_valid),
    .in_ready    (in_ready),
    .fifo_count  (i_fifo.count)
);

`default_nettype wire

//--- testbench/stream_link_tb.sv
`default_nettype none

module stream_link_tb;

    localparam int LANES    = 4;
    localparam int SYM_W    = 10;
    localparam int FRAME_W  = LANES * SYM_W;
    localparam int N_ROWS   = 6;
    localparam int MAX_WAIT = 200;
    // marker and pad of the lane encoding
    localparam logic [9:0] MARK = 10'h07E;
    localparam logic [9:0] PAD  = 10'h000;

    // one packet of the stimulus table
    typedef struct packed {
        int unsigned words;
        int unsigned start;
        int unsigned frames;
        int unsigned src;
        logic        gaps;
    } pkt_row_t;

    logic                txclk_div;
    logic                reset_n;
    logic [15:0]         rx_lo;
    logic [23:0]         rx_hi;
    lane_pkg::word_t     in_word;
    logic                in_valid;
    logic                in_ready;
    lane_pkg::link_cmd_t link_cmd;
    logic [FRAME_W-1:0]  frame;
    logic                frame_valid;

    pkt_row_t           table_rows [N_ROWS];
    logic [31:0]        pkt_data   [N_ROWS][8];
    int                 got_frames [N_ROWS];
    logic [FRAME_W-1:0] exp_frames [$];
    logic [31:0]        lcg_state;
    int                 errors;
    int                 tests_run;
    int                 tests_failed;
    int                 cycle_cnt = 0;
    int                 pkt_idx = 0;
    int                 marks_seen = 0;

    clock_gen i_clk (
        .txclk_div (txclk_div),
        .reset_n   (reset_n)
    );

    stream_link_top i_dut (
        .txclk_div   (txclk_div),
        .reset_n     (reset_n),
        .rx_lo       (rx_lo),
        .rx_hi       (rx_hi),
        .in_word     (in_word),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .link_cmd    (link_cmd),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

    always @(posedge txclk_div) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // two markers plus four symbols per word in whole frames
    function automatic int unsigned frames_for(input int unsigned words);
        return (words * 4 + 2 + LANES - 1) / LANES;
    endfunction

    task automatic next_cycle();
        @(posedge txclk_div);
        #1;
    endtask

    task automatic expect_cmd(input lane_pkg::link_cmd_t exp);
        if (link_cmd !== exp) begin
            $display("[FAIL] link_cmd: got %h expected %h", link_cmd, exp);
            errors++;
        end
    endtask

    task automatic wait_cycle(input int unsigned start);
        int n;
        n = 0;
        while (cycle_cnt < start && n < 2 * MAX_WAIT) begin
            next_cycle();
            n++;
        end
        if (cycle_cnt < start) begin
            $display("timeout waiting for start cycle %0d", start);
            errors++;
        end
    endtask

    // expected symbol stream of a packet cut into frames
    task automatic expect_packet(input int row);
        logic [9:0]         syms[$];
        logic [FRAME_W-1:0] f;
        int                 src;
        src = table_rows[row].src;
        syms.push_back(MARK);
        for (int w = 0; w < table_rows[row].words; w++) begin
            // byte 0 first
            for (int b = 0; b < 4; b++) begin
                syms.push_back({2'b01, pkt_data[src][w][8*b +: 8]});
            end
        end
        syms.push_back(MARK);
        while (syms.size() % LANES != 0) begin
            syms.push_back(PAD);
        end
        for (int k = 0; k < syms.size() / LANES; k++) begin
            for (int l = 0; l < LANES; l++) begin
                f[l*SYM_W +: SYM_W] = syms[k*LANES + l];
            end
            exp_frames.push_back(f);
        end
    endtask

    // hold the word until the fifo takes it
    task automatic send_word(input lane_pkg::word_t w);
        int waited;
        waited = 0;
        in_word  = w;
        in_valid = 1'b1;
        // in_ready only moves on a clock edge
        while (in_ready !== 1'b1 && waited < MAX_WAIT) begin
            next_cycle();
            waited++;
        end
        if (in_ready !== 1'b1) begin
            $display("timeout waiting for in_ready");
            errors++;
        end
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic send_packet(input int row);
        lane_pkg::word_t w;
        int              gap;
        wait_cycle(table_rows[row].start);
        expect_packet(row);
        for (int i = 0; i < table_rows[row].words; i++) begin
            if (table_rows[row].gaps) begin
                // idle stretch of one to four cycles empties the fifo
                gap = 1 + int'(lcg_next() % 32'd4);
                repeat (gap) next_cycle();
            end
            w.data = pkt_data[table_rows[row].src][i];
            w.last = (i == table_rows[row].words - 1);
            send_word(w);
        end
    endtask

    task automatic wait_frames_done();
        int n;
        n = 0;
        while (exp_frames.size() != 0 && n < MAX_WAIT) begin
            next_cycle();
            n++;
        end
        if (exp_frames.size() != 0) begin
            $display("timeout waiting for frames, %0d still missing", exp_frames.size());
            errors++;
        end
    endtask

    task automatic check_count(input int row);
        if (got_frames[row] != table_rows[row].frames) begin
            $display("[FAIL] frame count of packet %0d: got %h expected %h",
                     row, got_frames[row], table_rows[row].frames);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
        end
    endtask

    // frame checker samples one unit after the edge
    always @(posedge txclk_div) begin
        #1;
        if (frame_valid === 1'b1) begin
            if (link_cmd !== lane_pkg::CMD_DATA) begin
                $display("frame_valid went high before training finished");
                errors++;
            end
            if (exp_frames.size() == 0) begin
                $display("[FAIL] frame: got %h with no frame expected", frame);
                errors++;
            end else begin
                if (frame !== exp_frames[0]) begin
                    $display("[FAIL] frame: got %h expected %h", frame, exp_frames[0]);
                    errors++;
                end
                void'(exp_frames.pop_front());
            end
            // dut packets end at their second marker
            if (pkt_idx < N_ROWS) begin
                got_frames[pkt_idx]++;
            end
            for (int l = 0; l < LANES; l++) begin
                if (frame[l*SYM_W +: SYM_W] === MARK) begin
                    marks_seen++;
                end
            end
            if (marks_seen >= 2) begin
                pkt_idx++;
                marks_seen = 0;
            end
        end
    end

    initial begin
        int e0;
        rx_lo        = 16'h7E7F;
        rx_hi        = 24'h000000;
        in_word      = '0;
        in_valid     = 1'b0;
        lcg_state    = 32'd98097;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        // words, start cycle, frames, data source row, gaps
        table_rows[0] = '{8, 3, 0, 0, 1'b0};
        table_rows[1] = '{1, 60, 0, 1, 1'b0};
        table_rows[2] = '{2, 100, 0, 2, 1'b0};
        table_rows[3] = '{3, 0, 0, 3, 1'b0};
        table_rows[4] = '{5, 0, 0, 4, 1'b0};
        // same words as row 4 with idle gaps
        table_rows[5] = '{5, 200, 0, 4, 1'b1};
        for (int r = 0; r < N_ROWS; r++) begin
            table_rows[r].frames = frames_for(table_rows[r].words);
            got_frames[r] = 0;
            for (int i = 0; i < 8; i++) begin
                pkt_data[r][i] = lcg_next();
            end
        end

        // reset
        e0 = errors;
        next_cycle();
        expect_cmd(lane_pkg::CMD_DATA);
        if (frame_valid !== 1'b0) begin
            $display("[FAIL] frame_valid: got %h expected 0", frame_valid);
            errors++;
        end
        if (in_ready !== 1'b1) begin
            $display("[FAIL] in_ready: got %h expected 1", in_ready);
            errors++;
        end
        next_cycle();
        // middle of the first cycle out of reset
        #10;
        expect_cmd(lane_pkg::CMD_DATA);
        if (frame_valid !== 1'b0) begin
            $display("[FAIL] frame_valid: got %h expected 0", frame_valid);
            errors++;
        end
        if (frame !== {LANES{MARK}}) begin
            $display("[FAIL] frame: got %h expected %h", frame, {LANES{MARK}});
            errors++;
        end
        finish_test("reset", e0);

        // backlog fills the fifo while training waits
        e0 = errors;
        next_cycle();
        expect_cmd(lane_pkg::CMD_TRAIN_LO);
        send_packet(0);
        if (in_ready !== 1'b0) begin
            $display("[FAIL] in_ready: got %h expected 0", in_ready);
            errors++;
        end
        expect_cmd(lane_pkg::CMD_TRAIN_LO);
        rx_lo = 16'h7E7E;
        next_cycle();
        expect_cmd(lane_pkg::CMD_TRAIN_HI);
        // wrong high group reply first
        rx_hi = 24'h7E7E7F;
        next_cycle();
        expect_cmd(lane_pkg::CMD_TRAIN_HI);
        rx_hi = 24'h7E7E7E;
        next_cycle();
        expect_cmd(lane_pkg::CMD_SETTLE);
        repeat (4) begin
            next_cycle();
            expect_cmd(lane_pkg::CMD_DATA);
        end
        finish_test("training", e0);

        e0 = errors;
        wait_frames_done();
        check_count(0);
        finish_test("backlog", e0);

        e0 = errors;
        send_packet(1);
        wait_frames_done();
        check_count(1);
        finish_test("single word", e0);

        e0 = errors;
        send_packet(2);
        send_packet(3);
        send_packet(4);
        wait_frames_done();
        check_count(2);
        check_count(3);
        check_count(4);
        finish_test("back to back", e0);

        e0 = errors;
        send_packet(5);
        wait_frames_done();
        check_count(5);
        expect_cmd(lane_pkg::CMD_DATA);
        finish_test("input gaps", e0);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/frame_packer.sv
`default_nettype none

module frame_packer #(
    parameter int LANES = 4
) (
    input  wire logic                          txclk_div,
    input  wire logic                          reset_n,
    input  wire logic                          link_up,
    input  wire lane_pkg::word_t               head,
    input  wire logic                          head_valid,
    output logic                               pop,
    output lane_pkg::symbol_t [LANES-1:0]      frame,
    output logic                               frame_valid
);

    // one frame plus the tail of a word that did not fit
    localparam int HOLD_MAX = LANES + lane_pkg::WORD_BYTES - 1;
    localparam int CNT_W    = $clog2(HOLD_MAX + 1);
    localparam logic [CNT_W-1:0] LANES_C = CNT_W'(LANES);
    localparam logic [CNT_W-1:0] WORD_C  = CNT_W'(lane_pkg::WORD_BYTES);

    lane_pkg::symbol_t hold     [HOLD_MAX];
    lane_pkg::symbol_t hold_nxt [HOLD_MAX];
    lane_pkg::symbol_t [lane_pkg::WORD_BYTES-1:0] word_syms;
    lane_pkg::symbol_t [LANES-1:0]                frame_nxt;

    logic [CNT_W-1:0] fill;
    logic [CNT_W-1:0] fill_nxt;
    logic [CNT_W-1:0] base;
    logic             pkt_open;
    logic             last_seen;
    logic             closing;
    logic             full;
    logic             emit;
    logic             room;
    logic             take_start;
    logic             take_word;
    logic             take_end;

    // tag each byte of the head word
    always_comb begin
        for (int b = 0; b < lane_pkg::WORD_BYTES; b++) begin
            word_syms[b].tag   = lane_pkg::TAG_DATA;
            word_syms[b].value = head.data[8*b +: 8];
        end
    end

    // a whole frame is waiting
    assign full = (fill >= LANES_C);
    // after the end marker the partial frame goes out padded
    assign emit = full || (closing && fill != '0);

    // fill level once this cycle's frame has left
    always_comb begin
        if (full) begin
            base = fill - LANES_C;
        end else if (emit) begin
            base = '0;
        end else begin
            base = fill;
        end
    end

    // a word always fits while less than a frame remains
    assign room = link_up && !closing && (base < LANES_C);

    // chunk priority: start marker, word, end marker
    assign take_start = room && !pkt_open && head_valid;
    assign take_word  = room && pkt_open && !last_seen && head_valid;
    assign take_end   = room && last_seen;

    assign pop = take_word;

    always_comb begin
        if (take_word) begin
            fill_nxt = base + WORD_C;
        end else if (take_start || take_end) begin
            fill_nxt = base + 1'b1;
        end else begin
            fill_nxt = base;
        end
    end

    // shift out a sent frame, then append the chunk at base
    always_comb begin
        hold_nxt = hold;
        if (full) begin
            for (int i = 0; i < HOLD_MAX - LANES; i++) begin
                hold_nxt[i] = hold[i + LANES];
            end
        end
        if (take_start || take_end) begin
            hold_nxt[base] = lane_pkg::SYM_MARK;
        end
        if (take_word) begin
            for (int j = 0; j < lane_pkg::WORD_BYTES; j++) begin
                hold_nxt[base + CNT_W'(j)] = word_syms[j];
            end
        end
    end

    // lanes beyond the fill level carry pad
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            frame_nxt[l] = (CNT_W'(l) < fill) ? hold[l] : lane_pkg::SYM_PAD;
        end
    end

    // symbol storage
    always_ff @(posedge txclk_div) begin
        hold <= hold_nxt;
    end

    always_ff @(posedge txclk_div) begin
        if (reset_n) begin
            fill        <= '0;
            pkt_open    <= 1'b0;
            last_seen   <= 1'b0;
            closing     <= 1'b0;
            frame_valid <= 1'b0;
            // idle lanes show the marker
            frame       <= {LANES{lane_pkg::SYM_MARK}};
        end else begin
            fill        <= fill_nxt;
            frame_valid <= emit;
            if (emit) begin
                frame <= frame_nxt;
            end
            // packet fully flushed
            if (emit && base == '0) begin
                closing <= 1'b0;
            end
            if (take_start) begin
                pkt_open <= 1'b1;
            end
            if (take_word) begin
                last_seen <= head.last;
            end
            if (take_end) begin
                pkt_open  <= 1'b0;
                last_seen <= 1'b0;
                closing   <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/lane_pkg.sv
`default_nettype none

package lane_pkg;

    // one lane symbol, tag in the top two bits
    typedef struct packed {
        logic [1:0] tag;
        logic [7:0] value;
    } symbol_t;

    // data symbols carry tag 01 in front of the byte
    localparam logic [1:0] TAG_DATA = 2'b01;
    // frame start and end marker
    localparam symbol_t SYM_MARK = 10'h07E;
    // filler for unused lanes
    localparam symbol_t SYM_PAD = 10'h000;

    // input word, byte 0 goes out first
    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } word_t;

    localparam int WORD_BYTES = 4;

    // serializer command toward the partner board
    typedef enum logic [1:0] {
        CMD_DATA     = 2'b00,
        CMD_TRAIN_HI = 2'b01,
        CMD_TRAIN_LO = 2'b10,
        CMD_SETTLE   = 2'b11
    } link_cmd_t;

    // partner replies during training
    localparam logic [15:0] TRAIN_LO_ACK = 16'h7E7E;
    localparam logic [23:0] TRAIN_HI_ACK = 24'h7E7E7E;

endpackage

`default_nettype wire

//--- verilog/link_trainer.sv
`default_nettype none

module link_trainer (
    input  wire logic                txclk_div,
    input  wire logic                reset_n,
    input  wire logic [15:0]         rx_lo,
    input  wire logic [23:0]         rx_hi,
    output lane_pkg::link_cmd_t      link_cmd,
    output logic                     link_up
);

    // training steps
    typedef enum logic [2:0] {
        ST_RESET,
        ST_TRAIN_LO,
        ST_TRAIN_HI,
        ST_SETTLE,
        ST_DATA
    } state_t;

    state_t              state;
    state_t              state_nxt;
    lane_pkg::link_cmd_t cmd_nxt;

    // next step, advance on partner reply
    always_comb begin
        state_nxt = state;
        case (state)
            ST_RESET:    state_nxt = ST_TRAIN_LO;
            // low group first
            ST_TRAIN_LO: if (rx_lo == lane_pkg::TRAIN_LO_ACK) state_nxt = ST_TRAIN_HI;
            ST_TRAIN_HI: if (rx_hi == lane_pkg::TRAIN_HI_ACK) state_nxt = ST_SETTLE;
            // one cycle for the partner to turn around
            ST_SETTLE:   state_nxt = ST_DATA;
            default:     state_nxt = ST_DATA;
        endcase
    end

    // command that belongs to the coming step
    always_comb begin
        case (state_nxt)
            ST_TRAIN_LO: cmd_nxt = lane_pkg::CMD_TRAIN_LO;
            ST_TRAIN_HI: cmd_nxt = lane_pkg::CMD_TRAIN_HI;
            ST_SETTLE:   cmd_nxt = lane_pkg::CMD_SETTLE;
            default:     cmd_nxt = lane_pkg::CMD_DATA;
        endcase
    end

    always_ff @(posedge txclk_div) begin
        if (reset_n) begin
            state    <= ST_RESET;
            link_cmd <= lane_pkg::CMD_DATA;
            link_up  <= 1'b0;
        end else begin
            state    <= state_nxt;
            link_cmd <= cmd_nxt;
            // data stage stays until the next reset
            link_up  <= (state_nxt == ST_DATA);
        end
    end

endmodule

`default_nettype wire

//--- verilog/stream_link_top.sv
`default_nettype none

module stream_link_top #(
    parameter int LANES      = 4,
    parameter int FIFO_DEPTH = 8
) (
    input  wire logic                           txclk_div,
    input  wire logic                           reset_n,
    input  wire logic [15:0]                    rx_lo,
    input  wire logic [23:0]                    rx_hi,
    input  wire lane_pkg::word_t                in_word,
    input  wire logic                           in_valid,
    output wire logic                           in_ready,
    output wire lane_pkg::link_cmd_t            link_cmd,
    output wire lane_pkg::symbol_t [LANES-1:0]  frame,
    output wire logic                           frame_valid
);

    // trainer to packer
    wire logic            link_up;
    // fifo to packer
    wire lane_pkg::word_t head;
    wire logic            head_valid;
    wire logic            pop;

    // handshake with the partner board
    link_trainer i_trainer (
        .txclk_div (txclk_div),
        .reset_n   (reset_n),
        .rx_lo     (rx_lo),
        .rx_hi     (rx_hi),
        .link_cmd  (link_cmd),
        .link_up   (link_up)
    );

    // words wait here until the link is up
    word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .txclk_div  (txclk_div),
        .reset_n    (reset_n),
        .in_word    (in_word),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .head       (head),
        .head_valid (head_valid),
        .pop        (pop)
    );

    // packets into lane frames
    frame_packer #(
        .LANES (LANES)
    ) i_packer (
        .txclk_div   (txclk_div),
        .reset_n     (reset_n),
        .link_up     (link_up),
        .head        (head),
        .head_valid  (head_valid),
        .pop         (pop),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

endmodule

`default_nettype wire

//--- verilog/word_fifo.sv
`default_nettype none

module word_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire logic            txclk_div,
    input  wire logic            reset_n,
    input  wire lane_pkg::word_t in_word,
    input  wire logic            in_valid,
    output logic                 in_ready,
    output lane_pkg::word_t      head,
    output logic                 head_valid,
    input  wire logic            pop
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    lane_pkg::word_t  mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             do_pop;

    // room as long as not all slots are taken
    assign in_ready   = (count != CNT_W'(FIFO_DEPTH));
    assign head_valid = (count != '0);

    // show-ahead, oldest word always on head
    assign head = mem[rd_ptr];

    assign push   = in_valid && in_ready;
    // a pop on an empty buffer is dropped
    assign do_pop = pop && head_valid;

    // storage, no reset on payload
    always_ff @(posedge txclk_div) begin
        if (push) begin
            mem[wr_ptr] <= in_word;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge txclk_div) begin
        if (reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire
